//--- cpuPkg.sv
package cpuPkg;

	// ----------------------------------------------------------
	// Phase and opcode encodings.
	// ----------------------------------------------------------

	typedef enum logic [4:0] {
		STOPPED = 5'b00001,
		FETCH   = 5'b00010,
		DECODE  = 5'b00100,
		EXECUTE = 5'b01000,
		COMMIT  = 5'b10000
	} phaseT;

	// Codes 8 to 15 are no-operations.
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		XOR  = 4'h3,
		LDI  = 4'h4,
		ADDI = 4'h5,
		JMP  = 4'h6,
		HALT = 4'h7
	} opcodeT;

	typedef logic [8:0] pcT;

	// ----------------------------------------------------------
	// Instruction word.
	// ----------------------------------------------------------

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rd;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] pad;
	} regFormT;

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rd;
		logic [8:0] imm;
	} immFormT;

	// Same 16 bits, two views.
	typedef union packed {
		regFormT r;
		immFormT i;
	} instrT;

	// ----------------------------------------------------------
	// Stage results.
	// ----------------------------------------------------------

	typedef struct packed {
		opcodeT     op;
		logic [2:0] rd;
		logic [7:0] a;
		logic [7:0] b;
		logic [8:0] imm;
		pcT         pc;
		logic       writesReg;
		logic       isJump;
		logic       isHalt;
	} decodedT;

	typedef struct packed {
		opcodeT     op;
		logic [2:0] rd;
		logic [7:0] result;
		pcT         nextPc;
		logic       writesReg;
		logic       isHalt;
		pcT         pc;
	} execT;

	typedef struct packed {
		pcT         pc;
		logic [2:0] rd;
		logic [7:0] data;
		logic       writesReg;
	} commitT;

endpackage

//--- phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer (
	input  logic          CLK,
	input  logic          arstN,
	input  logic          debugStop,
	input  logic          debugStepReq,
	input  logic          haltReq,
	output cpuPkg::phaseT phase,
	output logic          debugStepAck,
	output logic          debugActive
);
	import cpuPkg::*;

	phaseT phaseNext;
	logic  stepping;
	logic  stepReqDly;
	logic  stepEdge;
	logic  halted;

	assign stepEdge = debugStepReq && !stepReqDly;

	// Debug and halt only act at instruction boundaries.
	always_comb begin
		phaseNext = phase;
		case (phase)
			STOPPED: begin
				if (!halted && (!debugStop || stepEdge))
					phaseNext = FETCH;
			end
			FETCH:   phaseNext = DECODE;
			DECODE:  phaseNext = EXECUTE;
			EXECUTE: phaseNext = COMMIT;
			COMMIT: begin
				if (haltReq || debugStop || stepping)
					phaseNext = STOPPED;
				else
					phaseNext = FETCH;
			end
			default: phaseNext = STOPPED;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			phase        <= STOPPED;
			stepping     <= 1'b0;
			stepReqDly   <= 1'b0;
			halted       <= 1'b0;
			debugStepAck <= 1'b0;
		end else begin
			phase      <= phaseNext;
			stepReqDly <= debugStepReq;

			// Leaving STOPPED with debugStop high can only be a step.
			if (phase == STOPPED && phaseNext == FETCH)
				stepping <= debugStop;
			else if (phase == COMMIT)
				stepping <= 1'b0;

			if (phase == COMMIT && haltReq)
				halted <= 1'b1;

			if (phase == COMMIT && stepping)
				debugStepAck <= 1'b1;
			else if (!debugStepReq || phaseNext != STOPPED)
				debugStepAck <= 1'b0;
		end
	end

	assign debugActive = (phase == STOPPED) && debugStop && !halted;

	phaseOneHot: assert property (@(posedge CLK) disable iff (!arstN) $onehot(phase));

	ackWhileStopped: assert property (@(posedge CLK) disable iff (!arstN)
		debugStepAck |-> phase == STOPPED);

endmodule

//--- fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
	parameter int pmemAddrWidth = 6
) (
	input  logic                     CLK,
	input  logic                     arstN,
	input  cpuPkg::phaseT            phase,
	input  logic                     progWe,
	input  logic [pmemAddrWidth-1:0] progAddr,
	input  cpuPkg::instrT            progData,
	input  logic                     pcLoad,
	input  cpuPkg::pcT               nextPc,
	output cpuPkg::instrT            instr,
	output cpuPkg::pcT               pc
);
	import cpuPkg::*;

	localparam int pmemDepth = 1 << pmemAddrWidth;
	localparam pcT pcMask    = pcT'(pmemDepth - 1);

	instrT pmem [pmemDepth];

	// Program load and instruction read.
	always_ff @(posedge CLK) begin
		if (progWe && phase == STOPPED)
			pmem[progAddr] <= progData;
		if (phase == FETCH)
			instr <= pmem[pc[pmemAddrWidth-1:0]];
	end

	// PC wraps to the memory depth.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			pc <= '0;
		else if (phase == COMMIT && pcLoad)
			pc <= nextPc & pcMask;
	end

	loadWhileStopped: assert property (@(posedge CLK) disable iff (!arstN)
		progWe |-> phase == STOPPED);

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic             CLK,
	input  logic             arstN,
	input  cpuPkg::phaseT    phase,
	input  cpuPkg::instrT    instr,
	input  cpuPkg::pcT       pc,
	input  logic             wrEn,
	input  logic [2:0]       wrReg,
	input  logic [7:0]       wrData,
	output cpuPkg::decodedT  dec
);
	import cpuPkg::*;

	logic [7:0] regs [8];
	decodedT    decNext;

	always_ff @(posedge CLK) begin
		if (wrEn)
			regs[wrReg] <= wrData;
	end

	// The opcode sits in the same bits in both forms.
	always_comb begin
		decNext    = '0;
		decNext.op = instr.r.opcode;
		decNext.pc = pc;
		case (instr.r.opcode)
			ADD, SUB, AND, XOR: begin
				decNext.rd        = instr.r.rd;
				decNext.a         = regs[instr.r.rs];
				decNext.b         = regs[instr.r.rt];
				decNext.writesReg = 1'b1;
			end
			LDI, ADDI, JMP: begin
				decNext.rd        = instr.i.rd;
				decNext.a         = regs[instr.i.rd];
				decNext.imm       = instr.i.imm;
				decNext.writesReg = instr.i.opcode != JMP;
				decNext.isJump    = instr.i.opcode == JMP;
			end
			HALT: decNext.isHalt = 1'b1;
			// Everything else passes as a no-operation.
			default: decNext.writesReg = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			dec <= '0;
		else if (phase == DECODE)
			dec <= decNext;
	end

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic            CLK,
	input  logic            arstN,
	input  cpuPkg::phaseT   phase,
	input  cpuPkg::decodedT dec,
	output cpuPkg::execT    ex
);
	import cpuPkg::*;

	logic [7:0] result;
	pcT         nextPc;

	// ----------------------------------------------------------
	// ALU.
	// ----------------------------------------------------------

	always_comb begin
		case (dec.op)
			ADD:     result = dec.a + dec.b;
			SUB:     result = dec.a - dec.b;
			AND:     result = dec.a & dec.b;
			XOR:     result = dec.a ^ dec.b;
			LDI:     result = dec.imm[7:0];
			ADDI:    result = dec.a + dec.imm[7:0];
			default: result = 8'h00;
		endcase
	end

	// Wrapping happens when fetch loads the PC.
	assign nextPc = dec.isJump ? dec.imm : dec.pc + pcT'(1);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ex <= '0;
		end else if (phase == EXECUTE) begin
			ex.op        <= dec.op;
			ex.rd        <= dec.rd;
			ex.result    <= result;
			ex.nextPc    <= nextPc;
			ex.writesReg <= dec.writesReg;
			ex.isHalt    <= dec.isHalt;
			ex.pc        <= dec.pc;
		end
	end

endmodule

//--- commitStage.sv
`timescale 1ns/1ps

module commitStage (
	input  logic           CLK,
	input  logic           arstN,
	input  cpuPkg::phaseT  phase,
	input  cpuPkg::execT   ex,
	output logic           wrEn,
	output logic [2:0]     wrReg,
	output logic [7:0]     wrData,
	output logic           pcLoad,
	output cpuPkg::pcT     nextPc,
	output logic           haltReq,
	output logic           commitValid,
	output cpuPkg::commitT commit
);
	import cpuPkg::*;

	logic inCommit;

	assign inCommit = phase == COMMIT;

	// Writeback and PC load land on the clock that ends COMMIT.
	assign wrEn    = inCommit && ex.writesReg;
	assign wrReg   = ex.rd;
	assign wrData  = ex.result;
	assign pcLoad  = inCommit && !ex.isHalt;
	assign nextPc  = ex.nextPc;
	assign haltReq = inCommit && ex.isHalt;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			commitValid <= 1'b0;
		else
			commitValid <= inCommit && !ex.isHalt;
	end

	always_ff @(posedge CLK) begin
		if (inCommit) begin
			commit.pc        <= ex.pc;
			commit.rd        <= ex.rd;
			commit.data      <= ex.result;
			commit.writesReg <= ex.writesReg;
		end
	end

endmodule

//--- cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
	parameter int pmemAddrWidth = 6
) (
	input  logic                     CLK,
	input  logic                     arstN,
	input  logic                     progWe,
	input  logic [pmemAddrWidth-1:0] progAddr,
	input  cpuPkg::instrT            progData,
	input  logic                     debugStop,
	input  logic                     debugStepReq,
	output logic                     debugStepAck,
	output logic                     debugActive,
	output logic                     commitValid,
	output cpuPkg::commitT           commit,
	output cpuPkg::phaseT            phase
);
	import cpuPkg::*;

	instrT      instr;
	pcT         pc;
	decodedT    dec;
	execT       ex;
	logic       wrEn;
	logic [2:0] wrReg;
	logic [7:0] wrData;
	logic       pcLoad;
	pcT         nextPc;
	logic       haltReq;

	phaseSequencer sequencer (
		.CLK(CLK), .arstN(arstN),
		.debugStop(debugStop), .debugStepReq(debugStepReq), .haltReq(haltReq),
		.phase(phase), .debugStepAck(debugStepAck), .debugActive(debugActive)
	);

	fetchStage #(.pmemAddrWidth(pmemAddrWidth)) fetch (
		.CLK(CLK), .arstN(arstN), .phase(phase),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.pcLoad(pcLoad), .nextPc(nextPc),
		.instr(instr), .pc(pc)
	);

	decodeStage decode (
		.CLK(CLK), .arstN(arstN), .phase(phase),
		.instr(instr), .pc(pc),
		.wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
		.dec(dec)
	);

	executeStage execute (
		.CLK(CLK), .arstN(arstN), .phase(phase),
		.dec(dec), .ex(ex)
	);

	// Closes the loop back to decode, fetch and the sequencer.
	commitStage commitUnit (
		.CLK(CLK), .arstN(arstN), .phase(phase), .ex(ex),
		.wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
		.pcLoad(pcLoad), .nextPc(nextPc), .haltReq(haltReq),
		.commitValid(commitValid), .commit(commit)
	);

endmodule

//--- tbCpuModel.svh
// ----------------------------------------------------------
// Instruction-set model.
// ----------------------------------------------------------

logic [7:0]  modelRegs [8];
logic [15:0] modelMem [pmemDepth];
pcT          modelPc;
commitT      expQ [$];
bit          jumpPending;
pcT          jumpTarget;
int          jumpCount;
int          immCount;

// Runs the word at the model PC straight from the ISA bit layout.
task automatic modelStep(output bit halted);
	logic [15:0] w;
	logic [7:0]  x;
	logic [7:0]  y;
	commitT      exp;
	pcT          target;
	w           = modelMem[modelPc[addrW-1:0]];
	x           = modelRegs[w[8:6]];
	y           = modelRegs[w[5:3]];
	exp         = '{pc: modelPc, rd: w[11:9], data: 8'h00, writesReg: 1'b1};
	target      = modelPc + pcT'(1);
	halted      = 1'b0;
	jumpPending = 1'b0;
	case (w[15:12])
		4'h0: exp.data = x + y;
		4'h1: exp.data = x - y;
		4'h2: exp.data = x & y;
		4'h3: exp.data = x ^ y;
		// LDI and ADDI differ only in opcode bit 0.
		4'h4, 4'h5: begin
			exp.data = w[7:0] + (w[12] ? modelRegs[w[11:9]] : 8'h00);
			if (w[12])
				immCount++;
		end
		4'h6: begin
			exp.writesReg = 1'b0;
			target        = w[8:0];
			jumpTarget    = w[8:0];
			jumpPending   = 1'b1;
			jumpCount++;
		end
		4'h7: halted = 1'b1;
		default: exp.writesReg = 1'b0;
	endcase
	if (!halted) begin
		if (exp.writesReg)
			modelRegs[exp.rd] = exp.data;
		expQ.push_back(exp);
		modelPc = pcT'(int'(target) % pmemDepth);
	end
endtask

//--- tbCpu.sv
`timescale 1ns/1ps

module tbCpu;
	import cpuPkg::*;

	localparam int addrW     = 6;
	localparam int pmemDepth = 1 << addrW;

	logic             CLK;
	logic             arstN;
	logic             progWe;
	logic [addrW-1:0] progAddr;
	instrT            progData;
	logic             debugStop;
	logic             debugStepReq;
	logic             debugStepAck;
	logic             debugActive;
	logic             commitValid;
	commitT           commit;
	phaseT            phase;
	logic [31:0]      lcgState;

	`include "tbCpuModel.svh"

	cpuTop #(.pmemAddrWidth(addrW)) dut (
		.CLK(CLK), .arstN(arstN),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.debugStop(debugStop), .debugStepReq(debugStepReq),
		.debugStepAck(debugStepAck), .debugActive(debugActive),
		.commitValid(commitValid), .commit(commit), .phase(phase)
	);

	always #20 CLK = ~CLK;

	// ----------------------------------------------------------
	// Checks.
	// ----------------------------------------------------------

	task automatic failRun(string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	// Register data is only meaningful when the commit writes.
	task automatic checkCommit(commitT got, commitT exp);
		if (got.pc !== exp.pc || got.writesReg !== exp.writesReg
				|| (exp.writesReg && (got.rd !== exp.rd || got.data !== exp.data)))
			failRun($sformatf("[ERROR] %0t: commit %0d/r%0d/%02h/%0b, expected %0d/r%0d/%02h/%0b",
				$time, got.pc, got.rd, got.data, got.writesReg,
				exp.pc, exp.rd, exp.data, exp.writesReg));
	endtask

	task automatic checkPhase(phaseT got, phaseT exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: phase %s, expected %s", $time, got.name(), exp.name()));
	endtask

	task automatic checkFlag(string what, logic got, logic exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// ----------------------------------------------------------
	// Stimulus.
	// ----------------------------------------------------------

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// ALU, immediate or jump word, never HALT.
	function automatic instrT randomInstr();
		logic [31:0] r;
		instrT       w;
		r          = nextRandom();
		w          = instrT'(r[31:16]);
		w.r.opcode = opcodeT'({1'b0, r[14:12]});
		if (w.r.opcode == HALT)
			w.r.opcode = ADDI;
		if (!r[14])
			w.r.pad = 3'b000;
		return w;
	endfunction

	task automatic loadProgram();
		for (int a = 0; a < pmemDepth; a++) begin
			@(negedge CLK);
			progWe   = 1'b1;
			progAddr = addrW'(a);
			progData = randomInstr();
			// First eight words set up r0 to r7.
			if (a < 8) begin
				progData.i.opcode = LDI;
				progData.i.rd     = 3'(a);
			end
			modelMem[progAddr] = progData;
		end
		@(negedge CLK);
		progWe = 1'b0;
	endtask

	task automatic expectCommit();
		bit     halted;
		commitT exp;
		if (jumpPending && int'(commit.pc) != int'(jumpTarget) % pmemDepth)
			failRun($sformatf("[ERROR] %0t: pc %0d after a jump to %0d",
				$time, commit.pc, jumpTarget));
		modelStep(halted);
		if (halted)
			failRun("A commit appeared where the model halts.");
		exp = expQ.pop_front();
		checkCommit(commit, exp);
	endtask

	task automatic waitCommit();
		for (int i = 0; i < 20; i++) begin
			@(negedge CLK);
			if (commitValid) begin
				expectCommit();
				return;
			end
		end
		failRun("Timed out waiting for a commit.");
	endtask

	task automatic waitStopped(output int seen);
		seen = 0;
		for (int i = 0; i < 12; i++) begin
			@(negedge CLK);
			if (commitValid) begin
				seen++;
				expectCommit();
			end
			if (phase == STOPPED)
				return;
		end
		failRun("Timed out waiting for the core to stop.");
	endtask

	task automatic quietCycles(int n);
		repeat (n) begin
			@(negedge CLK);
			checkFlag("commitValid", commitValid, 1'b0);
		end
	endtask

	task automatic stepOnce();
		int seen;
		seen = 0;
		@(negedge CLK);
		debugStepReq = 1'b1;
		for (int i = 0; i < 20 && !debugStepAck; i++) begin
			@(negedge CLK);
			if (commitValid) begin
				seen++;
				expectCommit();
			end
		end
		if (!debugStepAck)
			failRun("Timed out waiting for debugStepAck to rise.");
		if (seen != 1)
			failRun($sformatf("[ERROR] %0t: %0d commits for one step", $time, seen));
		// Ack holds while the request stays high.
		repeat (5) begin
			@(negedge CLK);
			checkFlag("debugStepAck", debugStepAck, 1'b1);
			checkFlag("commitValid", commitValid, 1'b0);
			checkPhase(phase, STOPPED);
		end
		debugStepReq = 1'b0;
		for (int i = 0; i < 4 && debugStepAck; i++)
			@(negedge CLK);
		if (debugStepAck)
			failRun("Timed out waiting for debugStepAck to fall.");
	endtask

	initial begin
		int seen;
		CLK          = 1'b0;
		arstN        = 1'b0;
		progWe       = 1'b0;
		progAddr     = '0;
		progData     = '0;
		debugStop    = 1'b1;
		debugStepReq = 1'b0;
		lcgState     = 32'h5b05_2c8a;
		modelPc      = '0;
		jumpPending  = 1'b0;
		jumpTarget   = '0;
		jumpCount    = 0;
		immCount     = 0;
		repeat (5) @(negedge CLK);
		arstN = 1'b1;

		loadProgram();
		checkPhase(phase, STOPPED);
		checkFlag("debugActive", debugActive, 1'b1);

		// Free run.
		debugStop = 1'b0;
		repeat (80) waitCommit();
		if (jumpCount == 0 || immCount == 0)
			failRun("The random program never used a jump or an ADDI.");

		// Debug stop lets at most the current instruction finish.
		debugStop = 1'b1;
		waitStopped(seen);
		if (seen > 1)
			failRun($sformatf("[ERROR] %0t: %0d commits after debugStop", $time, seen));
		checkFlag("debugActive", debugActive, 1'b1);
		quietCycles(50);

		repeat (4) stepOnce();
		debugStop = 1'b0;
		repeat (20) waitCommit();

		// HALT goes in at the next fetch address.
		debugStop = 1'b1;
		waitStopped(seen);
		@(negedge CLK);
		progWe             = 1'b1;
		progAddr           = modelPc[addrW-1:0];
		progData           = instrT'(16'h7000);
		modelMem[progAddr] = 16'h7000;
		@(negedge CLK);
		progWe    = 1'b0;
		debugStop = 1'b0;
		quietCycles(30);
		checkPhase(phase, STOPPED);
		checkFlag("debugActive", debugActive, 1'b0);

		debugStop    = 1'b1;
		debugStepReq = 1'b1;
		quietCycles(20);
		checkPhase(phase, STOPPED);
		checkFlag("debugActive", debugActive, 1'b0);
		checkFlag("debugStepAck", debugStepAck, 1'b0);
		debugStepReq = 1'b0;

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
cpuPkg.sv
phaseSequencer.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
commitStage.sv
cpuTop.sv
tbCpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tbCpu &&
./obj_dir/VtbCpu || exit 1
